//--- files.f
rtl/l1_cache_pkg.sv
rtl/cache_sram.sv
rtl/flush_walker.sv
rtl/cache_controller.sv
rtl/l1_cache.sv
sim/tb_clock.sv
sim/l1_cache_checker.sv
sim/l1_cache_assert.sv
sim/l1_cache_tb.sv

//--- rtl/cache_controller.sv
// direct-mapped write-back cache controller
// handles hits, line fill, victim write-back, flush and uncached pass-through
`timescale 1ns/1ps

module cache_controller (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              flush,
    input  l1_cache_pkg::proc_req_t           proc_req,
    output l1_cache_pkg::proc_rsp_t           proc_rsp,
    output l1_cache_pkg::mem_req_t            mem_req,
    input  l1_cache_pkg::mem_rsp_t            mem_rsp,
    output logic                              flush_done,
    output logic [l1_cache_pkg::SET_BITS-1:0] sram_sel,
    output logic                              sram_wen,
    output l1_cache_pkg::tag_entry_t          tag_wval,
    output l1_cache_pkg::tag_entry_t          tag_wmask,
    input  l1_cache_pkg::tag_entry_t          tag_rval,
    output l1_cache_pkg::line_t               data_wval,
    output l1_cache_pkg::line_t               data_wmask,
    input  l1_cache_pkg::line_t               data_rval
);
    import l1_cache_pkg::*;

    typedef enum logic [1:0] {HIT, FETCH, WB, FLUSH_CACHE} state_t;

    state_t                state, next_state;
    logic [BLOCK_BITS-1:0] word_cnt, next_word_cnt;
    word_t                 mem_addr, next_mem_addr;  // burst address
    cache_addr_t           req_addr, next_req_addr;  // access that missed
    logic                  flush_req;
    cache_addr_t           addr;
    logic                  access, pass_through, hit, abort, word_done, flush_pend;
    word_t                 lane_mask;
    flush_pos_t            pos;
    logic                  walk_clear, walk_step, walk_skip;

    flush_walker walker (
        .CLK       (CLK),
        .nRST      (nRST),
        .clear     (walk_clear),
        .step      (walk_step),
        .skip_line (walk_skip),
        .pos       (pos)
    );

    assign addr         = cache_addr_t'(proc_req.addr);
    assign access       = proc_req.ren || proc_req.wen;
    assign pass_through = proc_req.addr >= NONCACHE_BASE;
    assign hit          = !pass_through && tag_rval.valid && (tag_rval.tag == addr.tag);
    assign abort        = !access || (proc_req.addr != word_t'(req_addr)); // request withdrawn
    assign word_done    = !mem_rsp.busy && (word_cnt == BLOCK_BITS'(BLOCK_WORDS - 1));
    assign flush_pend   = flush || flush_req;

    // byte_en expanded to bit lanes
    always_comb begin
        for (int b = 0; b < WORD_BITS / 8; b++) begin
            lane_mask[8*b +: 8] = {8{proc_req.byte_en[b]}};
        end
    end

    always_comb begin
        case (state)
            FLUSH_CACHE: sram_sel = pos.set_idx;
            HIT:         sram_sel = addr.set_idx;
            default:     sram_sel = req_addr.set_idx;  // hold the missed set during a burst
        endcase
    end

    always_comb begin
        next_state      = state;
        next_word_cnt   = word_cnt;
        next_mem_addr   = mem_addr;
        next_req_addr   = req_addr;
        proc_rsp.busy   = 1'b1;
        proc_rsp.rdata  = '0;
        mem_req         = '0;
        mem_req.byte_en = '1;  // whole words for fills and evictions
        flush_done      = 1'b0;
        sram_wen        = 1'b0;
        tag_wval        = '0;
        tag_wmask       = '1;
        data_wval       = '0;
        data_wmask      = '1;
        walk_clear      = 1'b0;
        walk_step       = 1'b0;
        walk_skip       = 1'b0;

        case (state)
            HIT: begin
                next_word_cnt = '0;
                if (flush_pend) begin
                    next_state = FLUSH_CACHE;
                end else if (access && hit) begin
                    proc_rsp.busy  = 1'b0;
                    proc_rsp.rdata = data_rval[addr.word_idx];
                    if (proc_req.wen) begin
                        sram_wen                  = 1'b1;
                        data_wval[addr.word_idx]  = proc_req.wdata;
                        data_wmask[addr.word_idx] = ~lane_mask;
                        tag_wval.dirty            = 1'b1;
                        tag_wmask.dirty           = 1'b0;
                    end
                end else if (access && pass_through) begin
                    mem_req.ren     = proc_req.ren;
                    mem_req.wen     = proc_req.wen;
                    mem_req.addr    = proc_req.addr;
                    mem_req.byte_en = proc_req.byte_en;
                    mem_req.wdata   = proc_req.wdata & lane_mask;  // disabled lanes zero
                    proc_rsp.busy   = mem_rsp.busy;
                    proc_rsp.rdata  = mem_rsp.rdata;
                end else if (access) begin
                    next_req_addr = addr;
                    if (tag_rval.valid && tag_rval.dirty) begin
                        // evict the victim first
                        next_mem_addr = {tag_rval.tag, addr.set_idx, {(BLOCK_BITS + 2){1'b0}}};
                        next_state    = WB;
                    end else begin
                        next_mem_addr = {addr.tag, addr.set_idx, {(BLOCK_BITS + 2){1'b0}}};
                        next_state    = FETCH;
                    end
                end
            end
            FETCH: begin
                if (abort) begin
                    next_state = HIT;
                end else begin
                    mem_req.ren  = 1'b1;
                    mem_req.addr = mem_addr;
                    if (!mem_rsp.busy) begin
                        sram_wen             = 1'b1;
                        data_wval[word_cnt]  = mem_rsp.rdata;
                        data_wmask[word_cnt] = '0;
                        tag_wmask.valid      = 1'b0;  // invalid until the fill ends
                        next_word_cnt        = word_cnt + 1'b1;
                        next_mem_addr        = mem_addr + 32'd4;
                    end
                    if (word_done) begin
                        tag_wval.valid = 1'b1;
                        tag_wval.tag   = req_addr.tag;
                        tag_wmask      = '0;
                        next_word_cnt  = '0;
                        next_state     = HIT;
                    end
                end
            end
            WB: begin
                if (abort) begin
                    next_state = HIT;
                end else begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = mem_addr;
                    mem_req.wdata = data_rval[word_cnt];
                    if (!mem_rsp.busy) begin
                        next_word_cnt = word_cnt + 1'b1;
                        next_mem_addr = mem_addr + 32'd4;
                    end
                    if (word_done) begin
                        sram_wen      = 1'b1;
                        tag_wmask     = '0;  // victim gone, line now clean and invalid
                        next_word_cnt = '0;
                        next_mem_addr = {req_addr.tag, req_addr.set_idx, {(BLOCK_BITS + 2){1'b0}}};
                        next_state    = FETCH;
                    end
                end
            end
            FLUSH_CACHE: begin
                if (pos.finish) begin
                    flush_done = 1'b1;
                    walk_clear = 1'b1;
                    next_state = HIT;
                end else if (tag_rval.valid && tag_rval.dirty) begin
                    mem_req.wen   = 1'b1;
                    mem_req.addr  = {tag_rval.tag, pos.set_idx, pos.word_idx, 2'b00};
                    mem_req.wdata = data_rval[pos.word_idx];
                    if (!mem_rsp.busy) begin
                        walk_step = 1'b1;
                        // invalidate once the last word is out
                        if (pos.word_idx == BLOCK_BITS'(BLOCK_WORDS - 1)) begin
                            sram_wen  = 1'b1;
                            tag_wmask = '0;
                        end
                    end
                end else begin
                    sram_wen  = 1'b1;
                    tag_wmask = '0;
                    walk_skip = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= HIT;
            word_cnt  <= '0;
            mem_addr  <= '0;
            req_addr  <= '0;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            word_cnt  <= next_word_cnt;
            mem_addr  <= next_mem_addr;
            req_addr  <= next_req_addr;
            flush_req <= (state == FLUSH_CACHE) ? 1'b0 : flush_pend;  // held until flush starts
        end
    end

endmodule

//--- rtl/cache_sram.sv
// set-indexed storage array for the cache
// combinational read, masked write on the clock edge
`timescale 1ns/1ps

module cache_sram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = l1_cache_pkg::N_SETS
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic [$clog2(DEPTH)-1:0] sel,
    input  logic                     wen,
    input  payload_t                 wval,
    input  payload_t                 wmask,  // 1 keeps the stored bit
    output payload_t                 rval
);

    payload_t mem [DEPTH];
    payload_t merged;

    assign rval = mem[sel];

    // old bits where the mask is set, new bits elsewhere
    assign merged = payload_t'((mem[sel] & wmask) | (wval & ~wmask));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[sel] <= merged;
        end
    end

endmodule

//--- rtl/flush_walker.sv
// flush position counter
// walks every word of every set and flags when the last set is passed
`timescale 1ns/1ps

module flush_walker (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     clear,
    input  logic                     step,       // one word written back
    input  logic                     skip_line,  // nothing to write back here
    output l1_cache_pkg::flush_pos_t pos
);
    import l1_cache_pkg::*;

    flush_pos_t next_pos;
    logic       last_word;

    assign last_word = (pos.word_idx == BLOCK_BITS'(BLOCK_WORDS - 1));

    always_comb begin
        next_pos = pos;
        if (clear) begin
            next_pos = '0;
        end else if (skip_line || (step && last_word)) begin
            next_pos.word_idx = '0;
            if (pos.set_idx == SET_BITS'(N_SETS - 1)) begin
                next_pos.set_idx = '0;
                next_pos.finish  = 1'b1;
            end else begin
                next_pos.set_idx = pos.set_idx + 1'b1;
            end
        end else if (step) begin
            next_pos.word_idx = pos.word_idx + 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pos <= '0;
        end else begin
            pos <= next_pos;
        end
    end

endmodule

//--- rtl/l1_cache.sv
// l1 data cache top level
// controller plus the tag and data arrays
`timescale 1ns/1ps

module l1_cache (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    flush,
    output logic                    flush_done,
    input  l1_cache_pkg::proc_req_t proc_req,
    output l1_cache_pkg::proc_rsp_t proc_rsp,
    output l1_cache_pkg::mem_req_t  mem_req,
    input  l1_cache_pkg::mem_rsp_t  mem_rsp
);
    import l1_cache_pkg::*;

    logic [SET_BITS-1:0] sram_sel;
    logic                sram_wen;   // shared by both arrays
    tag_entry_t          tag_wval, tag_wmask, tag_rval;
    line_t               data_wval, data_wmask, data_rval;

    cache_controller ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush_done (flush_done),
        .sram_sel   (sram_sel),
        .sram_wen   (sram_wen),
        .tag_wval   (tag_wval),
        .tag_wmask  (tag_wmask),
        .tag_rval   (tag_rval),
        .data_wval  (data_wval),
        .data_wmask (data_wmask),
        .data_rval  (data_rval)
    );

    cache_sram #(.payload_t(tag_entry_t)) tag_array (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (sram_sel),
        .wen   (sram_wen),
        .wval  (tag_wval),
        .wmask (tag_wmask),
        .rval  (tag_rval)
    );

    cache_sram #(.payload_t(line_t)) data_array (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (sram_sel),
        .wen   (sram_wen),
        .wval  (data_wval),
        .wmask (data_wmask),
        .rval  (data_rval)
    );

endmodule

//--- rtl/l1_cache_pkg.sv
// l1 data cache shared definitions
// geometry, address split and the processor and memory bus structs
package l1_cache_pkg;

    // geometry
    localparam int WORD_BITS   = 32;
    localparam int CACHE_BYTES = 256;
    localparam int BLOCK_WORDS = 2;
    localparam int N_SETS      = CACHE_BYTES / (BLOCK_WORDS * (WORD_BITS / 8));
    localparam int SET_BITS    = $clog2(N_SETS);
    localparam int BLOCK_BITS  = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS    = WORD_BITS - SET_BITS - BLOCK_BITS - 2;

    localparam logic [WORD_BITS-1:0] NONCACHE_BASE = 32'hF000_0000; // uncached from here up

    typedef logic [WORD_BITS-1:0] word_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [SET_BITS-1:0]   set_idx;
        logic [BLOCK_BITS-1:0] word_idx;
        logic [1:0]            byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef word_t [BLOCK_WORDS-1:0] line_t;

    // processor side
    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } proc_rsp_t;

    // memory side
    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                  finish;   // walked past the last set
        logic [SET_BITS-1:0]   set_idx;
        logic [BLOCK_BITS-1:0] word_idx;
    } flush_pos_t;

endpackage

//--- sim/l1_cache_assert.sv
// bus protocol assertions for the l1 cache
`timescale 1ns/1ps

module l1_cache_assert (
    input logic                   CLK,
    input logic                   nRST,
    input logic                   flush_done,
    input l1_cache_pkg::mem_req_t mem_req,
    input l1_cache_pkg::mem_rsp_t mem_rsp
);

    ren_wen_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else $error("mem ren and wen high together");

    done_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else $error("flush_done longer than one cycle");

    // a stalled transfer keeps its strobe
    ren_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren && mem_rsp.busy) |=> mem_req.ren)
        else $error("mem ren dropped while memory busy");

    wen_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.wen && mem_rsp.busy) |=> mem_req.wen)
        else $error("mem wen dropped while memory busy");

endmodule

bind l1_cache l1_cache_assert u_assert (.*);

//--- sim/l1_cache_checker.sv
// response checker for the l1 cache testbench
// counts memory transfers, compares values and prints one line per test
`timescale 1ns/1ps

module l1_cache_checker (
    input logic                    CLK,
    input l1_cache_pkg::proc_req_t proc_req,
    input l1_cache_pkg::mem_req_t  mem_req,
    input l1_cache_pkg::mem_rsp_t  mem_rsp
);
    import l1_cache_pkg::*;

    int          rd_cnt, wr_cnt, errors, test_errs, passed, failed;
    logic        seen_first;
    logic [31:0] first_addr;

    // write data with the disabled byte lanes cleared
    function automatic logic [31:0] enabled_lanes(input logic [31:0] data,
                                                  input logic [3:0]  be);
        logic [31:0] res;
        res = '0;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    // one word moves on each edge with a strobe and memory not busy
    always @(posedge CLK) begin
        if ((mem_req.ren || mem_req.wen) && !mem_rsp.busy) begin
            if (!seen_first) first_addr = mem_req.addr;
            seen_first = 1'b1;
            if (mem_req.ren) rd_cnt++;
            else wr_cnt++;
            // uncached access goes straight through
            if ((proc_req.ren || proc_req.wen) && proc_req.addr >= NONCACHE_BASE) begin
                compare("mem_req.addr", proc_req.addr, mem_req.addr);
                if (mem_req.wen)
                    compare("mem_req.wdata", enabled_lanes(proc_req.wdata, proc_req.byte_en),
                            mem_req.wdata);
            end
        end
    end

    task automatic start_test();
        rd_cnt     = 0;
        wr_cnt     = 0;
        seen_first = 1'b0;
        test_errs  = 0;
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h got %h", name, exp, act);
            test_errs++;
            errors++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("ERROR %s", msg);
        test_errs++;
        errors++;
    endtask

    task automatic end_test(input int idx, input string op, input logic [31:0] addr,
                            input int exp_rd, input int exp_wr,
                            input logic chk_first, input logic [31:0] exp_first);
        compare("mem reads", exp_rd, rd_cnt);
        compare("mem writes", exp_wr, wr_cnt);
        if (chk_first) compare("first mem addr", exp_first, first_addr);
        if (test_errs == 0) passed++;
        else failed++;
        $display("test %0d %s addr %h: %s", idx, op, addr, (test_errs == 0) ? "ok" : "bad");
    endtask

    task automatic report();
        $display("tests %0d passed %0d failed %0d errors %0d", passed + failed, passed,
                 failed, errors);
    endtask

endmodule

//--- sim/l1_cache_tb.sv
// l1 cache testbench top
// memory model, stimulus table, shadow memory and final verdict
`timescale 1ns/1ps

module l1_cache_tb;
    import l1_cache_pkg::*;

    typedef enum {OP_READ, OP_WRITE, OP_FLUSH, OP_IDLE} op_e;

    typedef struct {
        op_e         op;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;  // taken from the shadow when applied
        int          exp_rd;
        int          exp_wr;
        logic        chk_first;
        logic [31:0] first_addr;
    } entry_t;

    logic        CLK, nRST, flush, flush_done;
    proc_req_t   proc_req;
    proc_rsp_t   proc_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic        mem_busy;
    logic [31:0] mem_model [logic [31:0]];
    logic [31:0] shadow [logic [31:0]];
    logic [31:0] rng;
    int          wait_cnt;
    logic        seen_req, seen_xfer;
    entry_t      table_q [$];

    tb_clock clk_gen (.CLK(CLK), .nRST(nRST));

    l1_cache dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (flush_done),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    l1_cache_checker chk (
        .CLK      (CLK),
        .proc_req (proc_req),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // power-up content hashed from the full word address
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return lcg_next(lcg_next({a[31:2], 2'b00} ^ 32'h102));
    endfunction

    function automatic logic [31:0] model_read(input mem_req_t r);
        logic [31:0] k;
        k = {r.addr[31:2], 2'b00};
        return mem_model.exists(k) ? mem_model[k] : init_word(k);
    endfunction

    function automatic logic [31:0] lane_merge(input logic [31:0] old, input logic [31:0] nw,
                                               input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    assign mem_rsp = {mem_busy, model_read(mem_req)};

    // sample transfers on the active edge
    always @(posedge CLK) begin
        seen_req  = mem_req.ren || mem_req.wen;
        seen_xfer = seen_req && !mem_rsp.busy;
        if (seen_xfer && mem_req.wen)
            mem_model[{mem_req.addr[31:2], 2'b00}] =
                lane_merge(model_read(mem_req), mem_req.wdata, mem_req.byte_en);
    end

    // busy cycles before each word count down on the falling edge
    always @(negedge CLK) begin
        if (seen_xfer) begin
            rng      = lcg_next(rng);
            wait_cnt = rng % 3;
        end else if (seen_req && wait_cnt > 0) begin
            wait_cnt--;
        end
        seen_xfer = 1'b0;
        seen_req  = 1'b0;
        mem_busy  = (wait_cnt != 0);
    end

    task automatic add_op(input op_e op, input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] wdata, input int rd, input int wr,
                          input logic [31:0] first);
        entry_t e;
        e.op         = op;
        e.addr       = addr;
        e.be         = be;
        e.wdata      = wdata;
        e.exp_rdata  = '0;
        e.exp_rd     = rd;
        e.exp_wr     = wr;
        e.chk_first  = (rd + wr > 0) && op != OP_FLUSH;
        e.first_addr = first;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [3:0] bes [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
        add_op(OP_READ, 32'h108, 4'hF, 0, 2, 0, 32'h108);  // cold miss
        add_op(OP_READ, 32'h108, 4'hF, 0, 0, 0, 0);
        foreach (bes[i]) begin
            add_op(OP_WRITE, 32'h108, bes[i], 32'hA1B2_C3D4 + 32'h1111 * i, 0, 0, 0);
            add_op(OP_READ, 32'h108, 4'hF, 0, 0, 0, 0);
        end
        add_op(OP_READ, 32'h208, 4'hF, 0, 2, 2, 32'h108);  // dirty victim out first
        add_op(OP_READ, 32'h108, 4'hF, 0, 2, 0, 32'h108);
        add_op(OP_IDLE, 0, 0, 0, 0, 0, 0);
        add_op(OP_WRITE, 32'hF000_0010, 4'b0101, 32'h5566_7788, 0, 1, 32'hF000_0010);
        add_op(OP_READ, 32'hF000_0010, 4'hF, 0, 1, 0, 32'hF000_0010);
        add_op(OP_WRITE, 32'h010, 4'hF, 32'h1234_5678, 2, 0, 32'h010);
        add_op(OP_WRITE, 32'h01C, 4'b0110, 32'hCAFE_F00D, 2, 0, 32'h018);
        add_op(OP_WRITE, 32'h040, 4'hF, 32'h0BAD_BEEF, 2, 0, 32'h040);
        add_op(OP_FLUSH, 0, 0, 0, 0, 6, 0);  // three dirty lines of two words each
        add_op(OP_READ, 32'h010, 4'hF, 0, 2, 0, 32'h010);
        add_op(OP_READ, 32'h01C, 4'hF, 0, 2, 0, 32'h018);
        add_op(OP_READ, 32'h040, 4'hF, 0, 2, 0, 32'h040);
    endtask

    task automatic run_access(inout entry_t e, input int idx);
        logic [31:0] key, got;
        logic        done;
        key            = {e.addr[31:2], 2'b00};
        proc_req.ren   = (e.op == OP_READ);
        proc_req.wen   = (e.op == OP_WRITE);
        proc_req.addr  = e.addr;
        proc_req.wdata = e.wdata;
        proc_req.byte_en = e.be;
        done = 1'b0;
        got  = '0;
        for (int n = 0; n < 200 && !done; n++) begin
            @(posedge CLK);
            if (!proc_rsp.busy) begin
                done = 1'b1;
                got  = proc_rsp.rdata;
            end
        end
        @(negedge CLK);
        proc_req.ren = 1'b0;
        proc_req.wen = 1'b0;
        if (!done) chk.note_error($sformatf("test %0d timed out waiting for busy low", idx));
        if (!shadow.exists(key)) shadow[key] = init_word(key);
        if (e.op == OP_WRITE) shadow[key] = lane_merge(shadow[key], e.wdata, e.be);
        e.exp_rdata = shadow[key];
        if (e.op == OP_READ && done) chk.compare("rdata", e.exp_rdata, got);
    endtask

    task automatic run_flush(input int idx);
        logic done;
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        done  = 1'b0;
        for (int n = 0; n < 2000 && !done; n++) begin
            @(posedge CLK);
            done = flush_done;
        end
        @(negedge CLK);
        if (!done) chk.note_error($sformatf("test %0d timed out waiting for flush_done", idx));
    endtask

    initial begin
        entry_t e;
        rng        = 32'h102;
        wait_cnt   = 0;
        seen_req   = 1'b0;
        seen_xfer  = 1'b0;
        flush      = 1'b0;
        proc_req   = '0;
        mem_busy   = 1'b0;
        build_table();
        for (int n = 0; n < 20 && nRST !== 1'b1; n++) begin
            @(posedge CLK);
        end
        if (nRST !== 1'b1) chk.note_error("reset was never released");
        @(negedge CLK);
        chk.compare("mem_req.ren", 0, mem_req.ren);
        chk.compare("mem_req.wen", 0, mem_req.wen);
        chk.compare("flush_done", 0, flush_done);
        foreach (table_q[i]) begin
            e = table_q[i];
            chk.start_test();
            case (e.op)
                OP_READ, OP_WRITE: run_access(e, i);
                OP_FLUSH:          run_flush(i);
                default:           repeat (2) @(negedge CLK);
            endcase
            chk.end_test(i, e.op.name(), e.addr, e.exp_rd, e.exp_wr, e.chk_first,
                         e.first_addr);
        end
        chk.report();
        if (chk.errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
// testbench clock and reset source
// 100 ns clock, reset held low for the first 3 cycles
`timescale 1ns/1ps

module tb_clock (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;  // release away from the active edge
    end

endmodule
